// ==== list.f ====
+incdir+.
rs_pkg.sv
rs_slot_pick.sv
rs_wakeup.sv
rs_issue_select.sv
rs_control.sv
rs_top.sv
tb_rs.sv

// ==== rs_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_control (
    input  logic clock,
    input  logic reset,
    input  rs_pkg::rs_entry_t [`RS_DISPATCH_WIDTH-1:0] incoming_woken,
    input  rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries_woken,
    input  rs_pkg::br_update_t br_update,
    input  rs_pkg::slot_mask_t leaving_alu,
    input  rs_pkg::slot_mask_t leaving_mult,
    input  rs_pkg::slot_mask_t leaving_br,
    input  logic [`RS_DISPATCH_WIDTH-1:0][`RS_DEPTH-1:0] slot_grant,
    output rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries,
    output rs_pkg::slot_mask_t free_slots,
    output rs_pkg::free_count_t free_count
);

    rs_pkg::slot_mask_t leaving;
    rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries_kept;
    rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries_next;
    rs_pkg::free_count_t free_count_next;

    // squash drops the entry, clear strips the resolved branch bits
    function automatic rs_pkg::rs_entry_t apply_branch(
        input rs_pkg::rs_entry_t e,
        input rs_pkg::br_update_t upd
    );
        rs_pkg::rs_entry_t r;
        r = e;
        if (upd.br_task == rs_pkg::br_squash && (e.br_mask & upd.mask) != '0) begin
            r.valid = 1'b0;
        end else if (upd.br_task == rs_pkg::br_clear) begin
            r.br_mask = e.br_mask & ~upd.mask;
        end
        return r;
    endfunction

    assign leaving = leaving_alu | leaving_mult | leaving_br;

    // stored entries after wakeup, issue and branch update
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entries_kept[i] = entries_woken[i];
            if (leaving[i]) begin
                entries_kept[i].valid = 1'b0;
            end
            entries_kept[i] = apply_branch(entries_kept[i], br_update);
            free_slots[i] = !entries_kept[i].valid;
        end
    end

    // new lanes land in the slots picked from free_slots
    always_comb begin
        rs_pkg::rs_entry_t lane;
        entries_next = entries_kept;
        for (int l = 0; l < `RS_DISPATCH_WIDTH; l++) begin
            lane = apply_branch(incoming_woken[l], br_update);
            for (int j = 0; j < `RS_DEPTH; j++) begin
                if (incoming_woken[l].valid && slot_grant[l][j]) begin
                    entries_next[j] = lane;
                end
            end
        end
    end

    // room offered to the dispatcher next cycle is capped at the lane count
    always_comb begin
        int free_total;
        free_total = 0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!entries_next[i].valid) begin
                free_total = free_total + 1;
            end
        end
        if (free_total > `RS_DISPATCH_WIDTH) begin
            free_count_next = rs_pkg::free_count_t'(`RS_DISPATCH_WIDTH);
        end else begin
            free_count_next = rs_pkg::free_count_t'(free_total);
        end
    end

    // entry array and dispatch room
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            free_count <= rs_pkg::free_count_t'(`RS_DISPATCH_WIDTH);
        end else begin
            entries <= entries_next;
            free_count <= free_count_next;
        end
    end

    generate
        for (genvar l = 0; l < `RS_DISPATCH_WIDTH; l++) begin : g_dispatch_check
            // the dispatcher must respect last cycle's count
            a_lane_within_count: assert property (
                @(posedge clock) disable iff (reset)
                incoming_woken[l].valid |-> (l < free_count)
            ) else $error("lane %0d valid beyond free_count %0d", l, free_count);

            a_write_to_free_slot: assert property (
                @(posedge clock) disable iff (reset)
                incoming_woken[l].valid |->
                    (slot_grant[l] != '0) && ((slot_grant[l] & ~free_slots) == '0)
            ) else $error("lane %0d written to an occupied slot", l);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== rs_issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_issue_select #(
    parameter int NUM_UNITS = 2,
    parameter rs_pkg::fu_class_t CLASS = rs_pkg::class_alu
) (
    input  logic clock,
    input  rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries,
    input  logic [NUM_UNITS-1:0] busy,
    output rs_pkg::rs_entry_t [NUM_UNITS-1:0] issued,
    output rs_pkg::slot_mask_t leaving
);

    rs_pkg::slot_mask_t req;
    logic [NUM_UNITS-1:0][`RS_DEPTH-1:0] entry_grant;

    // entries of this class with both operands available
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            req[i] = entries[i].valid
                && (entries[i].fu_class == CLASS)
                && entries[i].src1.ready
                && entries[i].src2.ready;
        end
    end

    // oldest slots first, at most one per unit
    rs_slot_pick #(
        .WIDTH(`RS_DEPTH),
        .COUNT(NUM_UNITS)
    ) u_pick (
        .req(req),
        .grant(entry_grant)
    );

    // k-th free unit takes the k-th picked entry, busy units get nothing
    always_comb begin
        int rank;
        rank = 0;
        issued = '0;
        leaving = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (!busy[u]) begin
                for (int k = 0; k < NUM_UNITS; k++) begin
                    if (k == rank) begin
                        for (int j = 0; j < `RS_DEPTH; j++) begin
                            if (entry_grant[k][j]) begin
                                issued[u] = entries[j];
                            end
                        end
                        leaving = leaving | entry_grant[k];
                    end
                end
                rank = rank + 1;
            end
        end
    end

    generate
        for (genvar u = 0; u < NUM_UNITS; u++) begin : g_busy_check
            a_busy_unit_idle: assert property (
                @(posedge clock) busy[u] |-> !issued[u].valid
            ) else $error("issue to busy unit %0d", u);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== rs_params.svh ====
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// station size
`define RS_DEPTH 8

// dispatch lanes, also the number of CDB ports
`define RS_DISPATCH_WIDTH 2

// function units per class
`define RS_NUM_ALU 2
`define RS_NUM_MULT 1
`define RS_NUM_BR 1

// field widths
`define RS_TAG_BITS 6
`define RS_BR_BITS 4
`define RS_ID_BITS 8

`endif

// ==== rs_pkg.sv ====
`default_nettype none

`include "rs_params.svh"

package rs_pkg;

    typedef logic [`RS_TAG_BITS-1:0] phys_tag_t;
    typedef logic [`RS_BR_BITS-1:0] br_mask_t;
    typedef logic [`RS_ID_BITS-1:0] op_id_t;
    typedef logic [`RS_DEPTH-1:0] slot_mask_t;
    typedef logic [$clog2(`RS_DISPATCH_WIDTH+1)-1:0] free_count_t;

    typedef enum logic [1:0] {class_alu, class_mult, class_br} fu_class_t;

    typedef enum logic [1:0] {br_none, br_squash, br_clear} br_task_t;

    typedef struct packed {
        phys_tag_t tag;
        logic ready;
    } src_operand_t;

    typedef struct packed {
        logic valid;
        fu_class_t fu_class;
        phys_tag_t dest_tag;
        src_operand_t src1;
        src_operand_t src2;
        br_mask_t br_mask;
        op_id_t op_id;
    } rs_entry_t;

    typedef struct packed {
        logic valid;
        phys_tag_t tag;
    } cdb_t;

    // mask selects the branch being squashed or cleared
    typedef struct packed {
        br_task_t br_task;
        br_mask_t mask;
    } br_update_t;

endpackage

`default_nettype wire

// ==== rs_slot_pick.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_slot_pick #(
    parameter int WIDTH = 8,
    parameter int COUNT = 2
) (
    input  logic [WIDTH-1:0] req,
    output logic [COUNT-1:0][WIDTH-1:0] grant
);

    // row r takes the lowest request bit left over by rows 0 to r-1
    always_comb begin
        logic [WIDTH-1:0] taken;
        logic found;
        taken = '0;
        grant = '0;
        for (int r = 0; r < COUNT; r++) begin
            found = 1'b0;
            for (int b = 0; b < WIDTH; b++) begin
                if (req[b] && !taken[b] && !found) begin
                    grant[r][b] = 1'b1;
                    taken[b] = 1'b1;
                    found = 1'b1;
                end
            end
        end
    end

    // rows never share a bit, so no slot or entry is handed out twice
    always_comb begin
        for (int r = 0; r < COUNT; r++) begin
            for (int s = r + 1; s < COUNT; s++) begin
                a_rows_disjoint: assert ((grant[r] & grant[s]) == '0)
                    else $error("slot pick rows %0d and %0d overlap", r, s);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_top (
    input  logic clock,
    input  logic reset,
    input  rs_pkg::rs_entry_t [`RS_DISPATCH_WIDTH-1:0] dispatch,
    input  rs_pkg::cdb_t [`RS_DISPATCH_WIDTH-1:0] cdb,
    input  rs_pkg::br_update_t br_update,
    input  logic [`RS_NUM_ALU-1:0] alu_busy,
    input  logic [`RS_NUM_MULT-1:0] mult_busy,
    input  logic [`RS_NUM_BR-1:0] br_busy,
    output rs_pkg::rs_entry_t [`RS_NUM_ALU-1:0] issued_alu,
    output rs_pkg::rs_entry_t [`RS_NUM_MULT-1:0] issued_mult,
    output rs_pkg::rs_entry_t [`RS_NUM_BR-1:0] issued_br,
    output rs_pkg::free_count_t free_count
);

    rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries;
    rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries_woken;
    rs_pkg::rs_entry_t [`RS_DISPATCH_WIDTH-1:0] incoming_woken;
    rs_pkg::slot_mask_t free_slots;
    rs_pkg::slot_mask_t leaving_alu;
    rs_pkg::slot_mask_t leaving_mult;
    rs_pkg::slot_mask_t leaving_br;
    logic [`RS_DISPATCH_WIDTH-1:0][`RS_DEPTH-1:0] slot_grant;

    rs_control u_control (
        .clock(clock),
        .reset(reset),
        .incoming_woken(incoming_woken),
        .entries_woken(entries_woken),
        .br_update(br_update),
        .leaving_alu(leaving_alu),
        .leaving_mult(leaving_mult),
        .leaving_br(leaving_br),
        .slot_grant(slot_grant),
        .entries(entries),
        .free_slots(free_slots),
        .free_count(free_count)
    );

    rs_wakeup u_wakeup (
        .entries(entries),
        .incoming(dispatch),
        .cdb(cdb),
        .entries_woken(entries_woken),
        .incoming_woken(incoming_woken)
    );

    rs_slot_pick #(
        .WIDTH(`RS_DEPTH),
        .COUNT(`RS_DISPATCH_WIDTH)
    ) u_dispatch_pick (
        .req(free_slots),
        .grant(slot_grant)
    );

    rs_issue_select #(
        .NUM_UNITS(`RS_NUM_ALU),
        .CLASS(rs_pkg::class_alu)
    ) u_issue_alu (
        .clock(clock),
        .entries(entries),
        .busy(alu_busy),
        .issued(issued_alu),
        .leaving(leaving_alu)
    );

    rs_issue_select #(
        .NUM_UNITS(`RS_NUM_MULT),
        .CLASS(rs_pkg::class_mult)
    ) u_issue_mult (
        .clock(clock),
        .entries(entries),
        .busy(mult_busy),
        .issued(issued_mult),
        .leaving(leaving_mult)
    );

    rs_issue_select #(
        .NUM_UNITS(`RS_NUM_BR),
        .CLASS(rs_pkg::class_br)
    ) u_issue_br (
        .clock(clock),
        .entries(entries),
        .busy(br_busy),
        .issued(issued_br),
        .leaving(leaving_br)
    );

endmodule

`default_nettype wire

// ==== rs_wakeup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_wakeup (
    input  rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries,
    input  rs_pkg::rs_entry_t [`RS_DISPATCH_WIDTH-1:0] incoming,
    input  rs_pkg::cdb_t [`RS_DISPATCH_WIDTH-1:0] cdb,
    output rs_pkg::rs_entry_t [`RS_DEPTH-1:0] entries_woken,
    output rs_pkg::rs_entry_t [`RS_DISPATCH_WIDTH-1:0] incoming_woken
);

    // sets the ready bit of any source whose tag is on a valid cdb port
    function automatic rs_pkg::rs_entry_t wake(
        input rs_pkg::rs_entry_t e,
        input rs_pkg::cdb_t [`RS_DISPATCH_WIDTH-1:0] bus
    );
        rs_pkg::rs_entry_t w;
        w = e;
        for (int p = 0; p < `RS_DISPATCH_WIDTH; p++) begin
            if (e.valid && bus[p].valid) begin
                if (e.src1.tag == bus[p].tag) begin
                    w.src1.ready = 1'b1;
                end
                if (e.src2.tag == bus[p].tag) begin
                    w.src2.ready = 1'b1;
                end
            end
        end
        return w;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entries_woken[i] = wake(entries[i], cdb);
        end
    end

    // lanes arriving this cycle see the same broadcast
    always_comb begin
        for (int l = 0; l < `RS_DISPATCH_WIDTH; l++) begin
            incoming_woken[l] = wake(incoming[l], cdb);
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rs -f list.f -o tb_rs_sim

status=0
./obj_dir/tb_rs_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
    echo "simulation run reported failure"
    exit 1
fi
echo "simulation run clean"

// ==== tb_rs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module tb_rs;

    localparam int CLOCK_PERIOD = 20;
    // reset, the six tests and some slack
    localparam int WATCHDOG_CYCLES = 2 + 1 + 40 + 100 + 200 + 200 + 2000 + 200;

    logic clock;
    logic reset;
    rs_pkg::rs_entry_t [`RS_DISPATCH_WIDTH-1:0] dispatch;
    rs_pkg::cdb_t [`RS_DISPATCH_WIDTH-1:0] cdb;
    rs_pkg::br_update_t br_update;
    logic [`RS_NUM_ALU-1:0] alu_busy;
    logic [`RS_NUM_MULT-1:0] mult_busy;
    logic [`RS_NUM_BR-1:0] br_busy;
    rs_pkg::rs_entry_t [`RS_NUM_ALU-1:0] issued_alu;
    rs_pkg::rs_entry_t [`RS_NUM_MULT-1:0] issued_mult;
    rs_pkg::rs_entry_t [`RS_NUM_BR-1:0] issued_br;
    rs_pkg::free_count_t free_count;

    // reference model of the entry array
    rs_pkg::rs_entry_t model [`RS_DEPTH];
    rs_pkg::slot_mask_t model_leaving;
    int model_free;
    integer seed;
    int checks;
    int errors;
    int tests_failed;
    int errors_at_start;
    rs_pkg::op_id_t next_id;

    // traffic mix in percent
    int dispatch_pct;
    int ready_pct;
    int cdb_pct;
    int busy_pct;
    int branch_pct;
    // a small range makes cdb hits common
    int tag_range;

    rs_top u_dut (.*);

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic compare(input string what, input logic [63:0] got, expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    function automatic rs_pkg::rs_entry_t visible(input rs_pkg::rs_entry_t e);
        if (!e.valid) return '0;
        return e;
    endfunction

    // sources named on a valid cdb port become ready
    function automatic rs_pkg::rs_entry_t woken(input rs_pkg::rs_entry_t e);
        rs_pkg::rs_entry_t w;
        w = e;
        for (int p = 0; p < `RS_DISPATCH_WIDTH; p++) begin
            if (cdb[p].valid && cdb[p].tag == e.src1.tag) w.src1.ready = 1'b1;
            if (cdb[p].valid && cdb[p].tag == e.src2.tag) w.src2.ready = 1'b1;
        end
        return w;
    endfunction

    function automatic rs_pkg::rs_entry_t branch_filter(input rs_pkg::rs_entry_t e);
        rs_pkg::rs_entry_t f;
        f = e;
        if (br_update.br_task == rs_pkg::br_squash && (e.br_mask & br_update.mask) != 0) begin
            f.valid = 1'b0;
        end
        if (br_update.br_task == rs_pkg::br_clear) f.br_mask = e.br_mask & ~br_update.mask;
        return f;
    endfunction

    task automatic make_entry(output rs_pkg::rs_entry_t e);
        e.valid = 1'b1;
        e.fu_class = rs_pkg::fu_class_t'(rand_below(3));
        e.dest_tag = rs_pkg::phys_tag_t'(rand_below(64));
        e.src1.tag = rs_pkg::phys_tag_t'(rand_below(tag_range));
        e.src1.ready = rand_below(100) < ready_pct;
        e.src2.tag = rs_pkg::phys_tag_t'(rand_below(tag_range));
        e.src2.ready = rand_below(100) < ready_pct;
        e.br_mask = rs_pkg::br_mask_t'(rand_below(16));
        e.op_id = next_id;
        next_id = next_id + 1'b1;
    endtask

    // legal traffic only, valid lanes packed from lane 0 and within free_count
    task automatic drive_random();
        rs_pkg::rs_entry_t e;
        int lanes;
        lanes = rand_below(model_free + 1);
        if (rand_below(100) >= dispatch_pct) lanes = 0;
        dispatch = '0;
        for (int l = 0; l < lanes; l++) begin
            make_entry(e);
            dispatch[l] = e;
        end
        for (int p = 0; p < `RS_DISPATCH_WIDTH; p++) begin
            cdb[p].valid = rand_below(100) < cdb_pct;
            cdb[p].tag = rs_pkg::phys_tag_t'(rand_below(tag_range));
        end
        br_update.br_task = rs_pkg::br_none;
        if (rand_below(100) < branch_pct) begin
            br_update.br_task = (rand_below(2) == 0) ? rs_pkg::br_squash : rs_pkg::br_clear;
        end
        br_update.mask = rs_pkg::br_mask_t'(1 << rand_below(`RS_BR_BITS));
        for (int u = 0; u < `RS_NUM_ALU; u++) alu_busy[u] = rand_below(100) < busy_pct;
        for (int u = 0; u < `RS_NUM_MULT; u++) mult_busy[u] = rand_below(100) < busy_pct;
        for (int u = 0; u < `RS_NUM_BR; u++) br_busy[u] = rand_below(100) < busy_pct;
    endtask

    // oldest ready entry of the class not yet handed to an earlier unit
    task automatic take_ready(input rs_pkg::fu_class_t cls, input logic busy,
                              output rs_pkg::rs_entry_t e);
        int pick;
        pick = -1;
        e = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (model[i].valid && model[i].fu_class == cls && model[i].src1.ready
                    && model[i].src2.ready && !model_leaving[i]) begin
                pick = i;
            end
        end
        if (!busy && pick >= 0) begin
            e = model[pick];
            model_leaving[pick] = 1'b1;
        end
    endtask

    task automatic check_outputs();
        rs_pkg::rs_entry_t e;
        model_leaving = '0;
        for (int u = 0; u < `RS_NUM_ALU; u++) begin
            take_ready(rs_pkg::class_alu, alu_busy[u], e);
            compare($sformatf("alu unit %0d issue", u), visible(issued_alu[u]), e);
        end
        for (int u = 0; u < `RS_NUM_MULT; u++) begin
            take_ready(rs_pkg::class_mult, mult_busy[u], e);
            compare($sformatf("mult unit %0d issue", u), visible(issued_mult[u]), e);
        end
        for (int u = 0; u < `RS_NUM_BR; u++) begin
            take_ready(rs_pkg::class_br, br_busy[u], e);
            compare($sformatf("branch unit %0d issue", u), visible(issued_br[u]), e);
        end
        compare("free_count", free_count, model_free);
    endtask

    // wakeup, issue removal, branch update, then the new lanes
    task automatic advance_model();
        rs_pkg::rs_entry_t lane;
        rs_pkg::slot_mask_t taken;
        int slot;
        int free_total;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            model[i] = woken(model[i]);
            if (model_leaving[i]) model[i].valid = 1'b0;
            model[i] = branch_filter(model[i]);
        end
        taken = '0;
        for (int l = 0; l < `RS_DISPATCH_WIDTH; l++) begin
            if (dispatch[l].valid) begin
                lane = branch_filter(woken(dispatch[l]));
                slot = -1;
                for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
                    if (!model[i].valid && !taken[i]) slot = i;
                end
                if (slot < 0) begin
                    $display("model error at %0t: lane %0d found no free entry", $time, l);
                    errors++;
                end else begin
                    model[slot] = lane;
                    taken[slot] = 1'b1;
                end
            end
        end
        free_total = 0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!model[i].valid) free_total++;
        end
        model_free = (free_total < `RS_DISPATCH_WIDTH) ? free_total : `RS_DISPATCH_WIDTH;
    endtask

    task automatic step();
        @(posedge clock);
        #2;
        drive_random();
        #8;
        check_outputs();
        advance_model();
    endtask

    task automatic set_mix(input int dispatch_p, input int ready_p, input int cdb_p,
                           input int busy_p, input int branch_p, input int tags);
        dispatch_pct = dispatch_p;
        ready_pct = ready_p;
        cdb_pct = cdb_p;
        busy_pct = busy_p;
        branch_pct = branch_p;
        tag_range = tags;
    endtask

    task automatic finish_test(input string name);
        if (errors != errors_at_start) tests_failed++;
        $display("test %s: %s with %0d errors", name,
                 (errors == errors_at_start) ? "ok" : "FAILED", errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        seed = 81;
        reset = 1'b1;
        dispatch = '0;
        cdb = '0;
        br_update = '0;
        alu_busy = '0;
        mult_busy = '0;
        br_busy = '0;
        checks = 0;
        errors = 0;
        tests_failed = 0;
        errors_at_start = 0;
        next_id = '0;
        model_free = `RS_DISPATCH_WIDTH;
        for (int i = 0; i < `RS_DEPTH; i++) model[i] = '0;
        set_mix(0, 0, 0, 0, 0, 64);
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        step();
        compare("free_count after reset", free_count, `RS_DISPATCH_WIDTH);
        finish_test("1 after reset");

        set_mix(100, 100, 0, 0, 0, 64);
        repeat (40) step();
        finish_test("2 ready dispatch");

        // every source waits for a broadcast
        set_mix(60, 0, 60, 0, 0, 8);
        repeat (100) step();
        finish_test("3 wakeup");

        set_mix(70, 50, 50, 50, 0, 8);
        repeat (200) step();
        finish_test("4 busy back-pressure");

        set_mix(70, 50, 50, 20, 40, 8);
        repeat (200) step();
        finish_test("5 branches");

        set_mix(60, 40, 50, 30, 10, 16);
        repeat (2000) step();
        finish_test("6 mixed random");

        $display("tests: 6, failed: %0d, checks: %0d, errors: %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(CLOCK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
